// ==== verilog/bus_pkg.sv ====
package bus_pkg;

	// processor side access codes
	typedef enum logic [2:0] {
		BUS_READ_B   = 3'd0,
		BUS_READ_BU  = 3'd1,
		BUS_READ_H   = 3'd2,
		BUS_READ_HU  = 3'd3,
		BUS_READ_W   = 3'd4,
		BUS_WRITE_B  = 3'd5,
		BUS_WRITE_H  = 3'd6,
		BUS_WRITE_W  = 3'd7
	} bus_op_t;

	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;
	typedef logic [7:0]  byte_t;
	typedef logic [2:0]  lane_cnt_t;
	typedef logic [1:0]  credit_t;

	// strobes allowed in flight without an acknowledge
	localparam int MAX_CREDITS = 2;

	function automatic lane_cnt_t op_bytes(input bus_op_t code);
		case (code)
			BUS_READ_W, BUS_WRITE_W:              op_bytes = 3'd4;
			BUS_READ_H, BUS_READ_HU, BUS_WRITE_H: op_bytes = 3'd2;
			default:                              op_bytes = 3'd1;
		endcase
	endfunction

	function automatic logic op_is_write(input bus_op_t code);
		op_is_write = (code == BUS_WRITE_B) || (code == BUS_WRITE_H) || (code == BUS_WRITE_W);
	endfunction

	// only the narrow loads without the U suffix extend by sign
	function automatic logic op_is_signed(input bus_op_t code);
		op_is_signed = (code == BUS_READ_B) || (code == BUS_READ_H);
	endfunction

endpackage

// ==== verilog/cache_pkg.sv ====
package cache_pkg;

	// direct mapped, one 32-bit word per line
	localparam int CACHE_ENTRIES = 16;
	localparam int OFFSET_BITS   = 2;
	localparam int INDEX_BITS    = 4;
	localparam int TAG_BITS      = 26;

	// index sits right above the byte offset, tag above the index
	localparam int INDEX_LSB = OFFSET_BITS;
	localparam int TAG_LSB   = OFFSET_BITS + INDEX_BITS;

	typedef logic [INDEX_BITS-1:0] cache_index_t;
	typedef logic [TAG_BITS-1:0]   cache_tag_t;

endpackage

// ==== verilog/lsu_control.sv ====
`timescale 1ns/1ps

module lsu_control (
	input  logic             CLK_I,
	input  logic             RST_I,
	input  logic             req,
	input  bus_pkg::bus_op_t op,
	input  bus_pkg::addr_t   addr,
	input  bus_pkg::word_t   wdata,
	output logic             ready,
	output logic             done,
	output bus_pkg::word_t   rdata,
	output logic             start_xfer,
	output bus_pkg::bus_op_t xfer_op,
	output bus_pkg::addr_t   xfer_addr,
	output bus_pkg::word_t   xfer_wdata,
	input  logic             issue_done,
	input  logic             xfer_done,
	input  bus_pkg::word_t   asm_data,
	output logic             lookup,
	output logic             fill,
	output bus_pkg::addr_t   cache_addr,
	input  logic             hit_valid,
	input  logic             hit,
	input  bus_pkg::word_t   hit_data,
	output logic             CYC_O,
	output logic             WE_O
);
	import bus_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOOKUP,
		ST_TRANSFER,
		ST_FINISH
	} lsu_state_t;

	lsu_state_t state_q;
	logic       cacheable_q;
	logic       accept;
	logic       req_cacheable;
	logic       cache_served;

	assign accept        = ready && req;
	// only aligned word reads live in the cache
	assign req_cacheable = (op == BUS_READ_W) && (addr[1:0] == 2'b00);
	assign cache_served  = (state_q == ST_LOOKUP) && hit_valid && hit;

	assign ready = (state_q == ST_IDLE);
	assign done  = (state_q == ST_FINISH);
	assign CYC_O = (state_q == ST_TRANSFER);
	assign WE_O  = CYC_O && op_is_write(xfer_op);

	// lookup is asked in the request cycle, so the hit comes back in LOOKUP
	assign lookup     = accept && req_cacheable;
	assign cache_addr = ready ? addr : xfer_addr;
	assign fill       = (state_q == ST_TRANSFER) && xfer_done && cacheable_q;

	always_ff @(posedge CLK_I) begin
		if (accept) begin
			xfer_op    <= op;
			xfer_addr  <= addr;
			xfer_wdata <= wdata;
		end
	end

	always_ff @(posedge CLK_I) begin
		if (RST_I) begin
			state_q     <= ST_IDLE;
			start_xfer  <= 1'b0;
			cacheable_q <= 1'b0;
		end else begin
			start_xfer <= 1'b0;
			case (state_q)
				ST_IDLE: begin
					if (accept) begin
						cacheable_q <= req_cacheable;
						// writes skip the cache and go straight to the bus
						if (op_is_write(op)) begin
							state_q    <= ST_TRANSFER;
							start_xfer <= 1'b1;
						end else begin
							state_q <= ST_LOOKUP;
						end
					end
				end
				ST_LOOKUP: begin
					if (cache_served) begin
						state_q <= ST_FINISH;
					end else begin
						state_q    <= ST_TRANSFER;
						start_xfer <= 1'b1;
					end
				end
				ST_TRANSFER: begin
					if (xfer_done && issue_done)
						state_q <= ST_FINISH;
				end
				default: begin
					state_q <= ST_IDLE;
				end
			endcase
		end
	end

	// result register holds between accesses, writes leave it alone
	always_ff @(posedge CLK_I) begin
		if (cache_served)
			rdata <= hit_data;
		else if ((state_q == ST_TRANSFER) && xfer_done && !op_is_write(xfer_op))
			rdata <= asm_data;
	end

endmodule

// ==== verilog/byte_lane_issue.sv ====
`timescale 1ns/1ps

module byte_lane_issue (
	input  logic             CLK_I,
	input  logic             RST_I,
	input  logic             start_xfer,
	input  bus_pkg::bus_op_t xfer_op,
	input  bus_pkg::addr_t   xfer_addr,
	input  bus_pkg::word_t   xfer_wdata,
	input  logic             ACK_I,
	output bus_pkg::addr_t   ADR_O,
	output bus_pkg::byte_t   DAT_O,
	output logic             STB_O,
	output logic             issue_done
);
	import bus_pkg::*;

	lane_cnt_t byte_total;
	lane_cnt_t sent_q;
	lane_cnt_t sent_now;
	credit_t   credit_q;
	// high while bytes of the access are still to go out
	logic      active_q;

	assign byte_total = op_bytes(xfer_op);

	// a new access counts from byte zero already in its start cycle
	assign sent_now = start_xfer ? lane_cnt_t'(0) : sent_q;

	// strobe while bytes remain and a credit is left
	assign STB_O = (start_xfer || active_q) && (credit_q != '0);

	// little endian, byte k at start address plus k
	assign ADR_O = xfer_addr + addr_t'(sent_now);
	assign DAT_O = xfer_wdata[8*sent_now[1:0] +: 8];

	assign issue_done = !start_xfer && !active_q;

	always_ff @(posedge CLK_I) begin
		if (RST_I) begin
			sent_q   <= '0;
			active_q <= 1'b0;
			credit_q <= credit_t'(MAX_CREDITS);
		end else begin
			if (start_xfer || active_q)
				active_q <= (sent_now + lane_cnt_t'(STB_O)) != byte_total;
			sent_q <= sent_now + lane_cnt_t'(STB_O);
			// an ACK frees its credit for the next cycle
			credit_q <= credit_q - credit_t'(STB_O) + credit_t'(ACK_I);
		end
	end

endmodule

// ==== verilog/read_assembler.sv ====
`timescale 1ns/1ps

module read_assembler (
	input  logic             CLK_I,
	input  logic             RST_I,
	input  logic             start_xfer,
	input  bus_pkg::bus_op_t xfer_op,
	input  bus_pkg::byte_t   DAT_I,
	input  logic             ACK_I,
	output logic             xfer_done,
	output bus_pkg::word_t   asm_data
);
	import bus_pkg::*;

	lane_cnt_t byte_total;
	lane_cnt_t ack_q;
	logic      busy_q;
	word_t     part_q;
	word_t     merged;
	logic      ext_bit;

	assign byte_total = op_bytes(xfer_op);
	assign xfer_done  = busy_q && ACK_I && (ack_q == byte_total - lane_cnt_t'(1));

	// current byte merged in so the last ACK cycle already sees the full word
	always_comb begin
		merged = part_q;
		if (ACK_I)
			merged[8*ack_q[1:0] +: 8] = DAT_I;
	end

	// extend from the top byte of the access
	always_comb begin
		ext_bit = (byte_total == 3'd1) ? merged[7] : merged[15];
		ext_bit = ext_bit && op_is_signed(xfer_op);
		case (byte_total)
			3'd1:    asm_data = {{24{ext_bit}}, merged[7:0]};
			3'd2:    asm_data = {{16{ext_bit}}, merged[15:0]};
			default: asm_data = merged;
		endcase
	end

	always_ff @(posedge CLK_I) begin
		if (RST_I) begin
			busy_q <= 1'b0;
			ack_q  <= '0;
		end else if (start_xfer) begin
			busy_q <= 1'b1;
			ack_q  <= '0;
		end else if (busy_q && ACK_I) begin
			ack_q <= ack_q + lane_cnt_t'(1);
			if (xfer_done)
				busy_q <= 1'b0;
		end
	end

	// writes only count acknowledges
	always_ff @(posedge CLK_I) begin
		if (busy_q && ACK_I && !op_is_write(xfer_op))
			part_q <= merged;
	end

endmodule

// ==== verilog/word_cache.sv ====
`timescale 1ns/1ps

module word_cache (
	input  logic           CLK_I,
	input  logic           RST_I,
	input  logic           lookup,
	input  logic           fill,
	input  bus_pkg::addr_t cache_addr,
	input  bus_pkg::word_t fill_data,
	input  logic           STB_O,
	input  logic           WE_O,
	input  bus_pkg::addr_t ADR_O,
	output logic           hit_valid,
	output logic           hit,
	output bus_pkg::word_t hit_data
);
	import bus_pkg::*;
	import cache_pkg::*;

	logic [CACHE_ENTRIES-1:0] valid_q;
	cache_tag_t               tag_mem  [CACHE_ENTRIES];
	word_t                    data_mem [CACHE_ENTRIES];

	cache_index_t req_index;
	cache_tag_t   req_tag;
	cache_index_t inv_index;
	cache_tag_t   inv_tag;
	logic         inv_match;

	assign req_index = cache_addr[INDEX_LSB +: INDEX_BITS];
	assign req_tag   = cache_addr[TAG_LSB +: TAG_BITS];

	// every write byte is checked against the word it falls in
	assign inv_index = ADR_O[INDEX_LSB +: INDEX_BITS];
	assign inv_tag   = ADR_O[TAG_LSB +: TAG_BITS];
	assign inv_match = STB_O && WE_O && valid_q[inv_index] && (tag_mem[inv_index] == inv_tag);

	always_ff @(posedge CLK_I) begin
		if (RST_I) begin
			valid_q <= '0;
		end else begin
			if (fill)
				valid_q[req_index] <= 1'b1;
			// a write hitting the line wins over a fill
			if (inv_match)
				valid_q[inv_index] <= 1'b0;
		end
	end

	always_ff @(posedge CLK_I) begin
		if (fill) begin
			tag_mem[req_index]  <= req_tag;
			data_mem[req_index] <= fill_data;
		end
	end

	// registered answer, one cycle after the lookup pulse
	always_ff @(posedge CLK_I) begin
		if (RST_I) begin
			hit_valid <= 1'b0;
			hit       <= 1'b0;
		end else begin
			hit_valid <= lookup;
			if (lookup)
				hit <= valid_q[req_index] && (tag_mem[req_index] == req_tag);
		end
	end

	always_ff @(posedge CLK_I) begin
		if (lookup)
			hit_data <= data_mem[req_index];
	end

endmodule

// ==== verilog/wb8_lsu_top.sv ====
`timescale 1ns/1ps

module wb8_lsu_top (
	input  logic             CLK_I,
	input  logic             RST_I,
	input  logic             req,
	input  bus_pkg::bus_op_t op,
	input  bus_pkg::addr_t   addr,
	input  bus_pkg::word_t   wdata,
	output logic             ready,
	output logic             done,
	output bus_pkg::word_t   rdata,
	output bus_pkg::addr_t   ADR_O,
	output bus_pkg::byte_t   DAT_O,
	output logic             CYC_O,
	output logic             STB_O,
	output logic             WE_O,
	input  bus_pkg::byte_t   DAT_I,
	input  logic             ACK_I
);
	import bus_pkg::*;

	logic    start_xfer;
	bus_op_t xfer_op;
	addr_t   xfer_addr;
	word_t   xfer_wdata;
	logic    issue_done;
	logic    xfer_done;
	word_t   asm_data;
	logic    lookup;
	logic    fill;
	addr_t   cache_addr;
	logic    hit_valid;
	logic    hit;
	word_t   hit_data;

	lsu_control u_control (
		.CLK_I      (CLK_I),
		.RST_I      (RST_I),
		.req        (req),
		.op         (op),
		.addr       (addr),
		.wdata      (wdata),
		.ready      (ready),
		.done       (done),
		.rdata      (rdata),
		.start_xfer (start_xfer),
		.xfer_op    (xfer_op),
		.xfer_addr  (xfer_addr),
		.xfer_wdata (xfer_wdata),
		.issue_done (issue_done),
		.xfer_done  (xfer_done),
		.asm_data   (asm_data),
		.lookup     (lookup),
		.fill       (fill),
		.cache_addr (cache_addr),
		.hit_valid  (hit_valid),
		.hit        (hit),
		.hit_data   (hit_data),
		.CYC_O      (CYC_O),
		.WE_O       (WE_O)
	);

	byte_lane_issue u_issue (
		.CLK_I      (CLK_I),
		.RST_I      (RST_I),
		.start_xfer (start_xfer),
		.xfer_op    (xfer_op),
		.xfer_addr  (xfer_addr),
		.xfer_wdata (xfer_wdata),
		.ACK_I      (ACK_I),
		.ADR_O      (ADR_O),
		.DAT_O      (DAT_O),
		.STB_O      (STB_O),
		.issue_done (issue_done)
	);

	read_assembler u_assembler (
		.CLK_I      (CLK_I),
		.RST_I      (RST_I),
		.start_xfer (start_xfer),
		.xfer_op    (xfer_op),
		.DAT_I      (DAT_I),
		.ACK_I      (ACK_I),
		.xfer_done  (xfer_done),
		.asm_data   (asm_data)
	);

	// the cache snoops the bus outputs for write strobes
	word_cache u_cache (
		.CLK_I      (CLK_I),
		.RST_I      (RST_I),
		.lookup     (lookup),
		.fill       (fill),
		.cache_addr (cache_addr),
		.fill_data  (asm_data),
		.STB_O      (STB_O),
		.WE_O       (WE_O),
		.ADR_O      (ADR_O),
		.hit_valid  (hit_valid),
		.hit        (hit),
		.hit_data   (hit_data)
	);

endmodule

// ==== verification/wb8_mem_model.sv ====
`timescale 1ns/1ps

module wb8_mem_model #(
	parameter int DEPTH = 256
) (
	input  logic           CLK_I,
	input  logic           RST_I,
	input  bus_pkg::addr_t ADR_O,
	input  bus_pkg::byte_t DAT_O,
	input  logic           CYC_O,
	input  logic           STB_O,
	input  logic           WE_O,
	input  logic [1:0]     ack_lat,
	output bus_pkg::byte_t DAT_I,
	output logic           ACK_I
);
	import bus_pkg::*;

	byte_t mem [DEPTH];
	int    due_q [$];
	byte_t data_q [$];
	int    cycle;
	int    last_due;
	int    due;
	int    idx;
	int    i;

	initial begin
		ACK_I    = 1'b0;
		DAT_I    = '0;
		cycle    = 0;
		last_due = -1;
		for (i = 0; i < DEPTH; i++)
			mem[i] = byte_t'((i * 37) ^ (i >> 3) ^ 8'ha5);
	end

	always @(posedge CLK_I) begin
		if (RST_I) begin
			ACK_I <= 1'b0;
			due_q.delete();
			data_q.delete();
			last_due = cycle - 1;
		end else begin
			ACK_I <= 1'b0;
			if (CYC_O && STB_O) begin
				idx = int'(ADR_O % DEPTH);
				if (WE_O)
					mem[idx] = DAT_O;
				// ack lands 1 to 4 cycles later and never before the previous one
				due = cycle + int'(ack_lat);
				if (due <= last_due)
					due = last_due + 1;
				last_due = due;
				due_q.push_back(due);
				data_q.push_back(mem[idx]);
			end
			if (due_q.size() != 0 && due_q[0] == cycle) begin
				ACK_I <= 1'b1;
				DAT_I <= data_q.pop_front();
				due   = due_q.pop_front();
			end
		end
		cycle = cycle + 1;
	end

endmodule

// ==== verification/wb8_lsu_tb.sv ====
`timescale 1ns/1ps

module wb8_lsu_tb;
	import bus_pkg::*;

	localparam int          N_ACCESSES        = 300;
	localparam int          CYCLES_PER_ACCESS = 40;
	localparam logic [31:0] SEED              = 32'h2328_482d;

	logic       CLK_I;
	logic       RST_I;
	logic       req;
	bus_op_t    op;
	addr_t      addr;
	word_t      wdata;
	logic       ready;
	logic       done;
	word_t      rdata;
	addr_t      ADR_O;
	byte_t      DAT_O;
	logic       CYC_O;
	logic       STB_O;
	logic       WE_O;
	byte_t      DAT_I;
	logic       ACK_I;
	logic [1:0] ack_lat;

	logic [31:0] stim_state;
	logic [31:0] lat_state;
	logic [31:0] lat_bits;
	logic [31:0] r;
	bus_op_t     rnd_op;
	addr_t       rnd_addr;
	// shadow of the bus memory and of the cache contents
	byte_t       shadow [256];
	logic        c_valid [16];
	addr_t       c_addr [16];
	word_t       exp_data;
	lane_cnt_t   exp_strobes;
	lane_cnt_t   stb_cnt;
	addr_t       cur_addr;
	addr_t       stb_addr;
	bus_op_t     cur_op;
	int          outstanding;
	int          n_issued;
	int          n_done;
	int          i;

	wb8_lsu_top DUT (.*);

	wb8_mem_model #(.DEPTH(256)) mem_u (.*);

	initial begin
		CLK_I = 1'b0;
		forever #5 CLK_I = ~CLK_I;
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw(inout logic [31:0] st, input int nbits, output logic [31:0] val);
		int b;
		val = '0;
		for (b = 0; b < nbits; b++) begin
			st  = lfsr_step(st);
			val = {val[30:0], st[0]};
		end
	endtask

	function automatic int access_bytes(input bus_op_t f_op);
		case (f_op)
			BUS_READ_W, BUS_WRITE_W:              return 4;
			BUS_READ_H, BUS_READ_HU, BUS_WRITE_H: return 2;
			default:                              return 1;
		endcase
	endfunction

	// byte k comes from start address plus k, then sign or zero extension
	function automatic word_t expected_load(input bus_op_t f_op, input addr_t f_addr);
		word_t raw;
		addr_t ba;
		int    k;
		raw = '0;
		for (k = 0; k < access_bytes(f_op); k++) begin
			ba = f_addr + addr_t'(k);
			raw[8*k +: 8] = shadow[ba[7:0]];
		end
		case (f_op)
			BUS_READ_B: return {{24{raw[7]}}, raw[7:0]};
			BUS_READ_H: return {{16{raw[15]}}, raw[15:0]};
			default:    return raw;
		endcase
	endfunction

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_word(input word_t got, input word_t exp, input string what);
		if (got !== exp)
			abort_run($sformatf("[FAIL] %0t ns %s: got %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_count(input lane_cnt_t got, input lane_cnt_t exp, input string what);
		if (got !== exp)
			abort_run($sformatf("[FAIL] %0t ns %s: got %0d, expected %0d", $time, what, got, exp));
	endtask

	task automatic check_addr(input addr_t got, input addr_t exp, input string what);
		if (got !== exp)
			abort_run($sformatf("[FAIL] %0t ns %s: got %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_byte(input byte_t got, input byte_t exp, input string what);
		if (got !== exp)
			abort_run($sformatf("[FAIL] %0t ns %s: got %h, expected %h", $time, what, got, exp));
	endtask

	task automatic do_access(input bus_op_t a_op, input addr_t a_addr, input word_t a_wdata);
		int    n;
		int    k;
		addr_t ba;
		int    idx;
		// the previous access has been checked once ready shows again
		do
			@(posedge CLK_I);
		while (!ready);
		n           = access_bytes(a_op);
		exp_strobes = lane_cnt_t'(n);
		idx         = int'(a_addr[5:2]);
		if (a_op >= BUS_WRITE_B) begin
			for (k = 0; k < n; k++) begin
				ba = a_addr + addr_t'(k);
				shadow[ba[7:0]] = a_wdata[8*k +: 8];
				// any written byte drops the cached word that holds it
				if (c_valid[ba[5:2]] && c_addr[ba[5:2]] == {ba[31:2], 2'b00})
					c_valid[ba[5:2]] = 1'b0;
			end
		end else begin
			exp_data = expected_load(a_op, a_addr);
			if (a_op == BUS_READ_W && a_addr[1:0] == 2'b00) begin
				if (c_valid[idx] && c_addr[idx] == a_addr)
					exp_strobes = '0;
				c_valid[idx] = 1'b1;
				c_addr[idx]  = a_addr;
			end
		end
		req   <= 1'b1;
		op    <= a_op;
		addr  <= a_addr;
		wdata <= a_wdata;
		@(posedge CLK_I);
		req <= 1'b0;
		n_issued++;
	endtask

	always @(posedge CLK_I) begin
		draw(lat_state, 2, lat_bits);
		ack_lat <= lat_bits[1:0];
	end

	// bus monitor and result compare
	always @(posedge CLK_I) begin
		if (RST_I) begin
			outstanding = 0;
			n_done      = 0;
			stb_cnt     = '0;
		end else begin
			if (req && ready) begin
				stb_cnt  = '0;
				cur_addr = addr;
				cur_op   = op;
			end
			if (STB_O) begin
				if (!CYC_O || WE_O !== (cur_op >= BUS_WRITE_B))
					abort_run("STB_O came without CYC_O or with the wrong WE_O");
				stb_addr = cur_addr + addr_t'(stb_cnt);
				check_addr(ADR_O, stb_addr, "ADR_O of strobe");
				// the shadow already holds the bytes this write puts on the bus
				if (WE_O)
					check_byte(DAT_O, shadow[stb_addr[7:0]], "DAT_O of write strobe");
				stb_cnt = stb_cnt + 1'b1;
			end
			outstanding = outstanding + int'(STB_O) - int'(ACK_I);
			if (outstanding > MAX_CREDITS || outstanding < 0)
				abort_run($sformatf("strobes without acknowledge out of range: %0d", outstanding));
			if (done) begin
				check_count(stb_cnt, exp_strobes, "strobes of the access");
				if (cur_op < BUS_WRITE_B)
					check_word(rdata, exp_data, "load result");
				n_done++;
			end
		end
	end

	initial begin
		repeat (8 + N_ACCESSES * CYCLES_PER_ACCESS) @(posedge CLK_I);
		abort_run("timeout: the accesses did not finish in the allowed time");
	end

	initial begin
		RST_I      = 1'b1;
		req        = 1'b0;
		op         = BUS_READ_W;
		addr       = '0;
		wdata      = '0;
		ack_lat    = 2'd0;
		stim_state = SEED;
		lat_state  = SEED;
		n_issued   = 0;
		for (i = 0; i < 16; i++)
			c_valid[i] = 1'b0;
		repeat (8) @(posedge CLK_I);
		RST_I <= 1'b0;
		@(posedge CLK_I);
		if (ready !== 1'b1 || CYC_O !== 1'b0 || STB_O !== 1'b0 || done !== 1'b0)
			abort_run("handshake or bus outputs are not idle after reset");
		// word writes over the whole memory so every shadow byte is known
		for (i = 0; i < 256; i += 4) begin
			draw(stim_state, 32, r);
			do_access(BUS_WRITE_W, addr_t'(i), r);
		end
		// cache hit, byte write into the cached word, then narrow loads
		do_access(BUS_READ_W, 32'h40, '0);
		do_access(BUS_READ_W, 32'h40, '0);
		do_access(BUS_WRITE_B, 32'h41, 32'h0000_00c3);
		do_access(BUS_READ_W, 32'h40, '0);
		do_access(BUS_READ_B, 32'h41, '0);
		do_access(BUS_READ_BU, 32'h41, '0);
		do_access(BUS_WRITE_H, 32'h66, 32'h0000_8001);
		do_access(BUS_READ_H, 32'h66, '0);
		do_access(BUS_READ_HU, 32'h66, '0);
		while (n_issued < N_ACCESSES) begin
			draw(stim_state, 3, r);
			rnd_op = bus_op_t'(r[2:0]);
			draw(stim_state, 9, r);
			// half the word reads stay aligned in the low 64 bytes to revisit lines
			if (rnd_op == BUS_READ_W && r[8])
				r[7:0] = {2'b00, r[5:2], 2'b00};
			if (int'(r[7:0]) > 256 - access_bytes(rnd_op))
				r[7:0] = r[7:0] - 8'd4;
			rnd_addr = addr_t'(r[7:0]);
			draw(stim_state, 32, r);
			do_access(rnd_op, rnd_addr, r);
		end
		do
			@(posedge CLK_I);
		while (!ready);
		if (n_done == N_ACCESSES && outstanding == 0) begin
			$display("Simulation passed");
			$finish;
		end else begin
			abort_run("not every access completed with all of its acknowledges");
		end
	end

endmodule

// ==== compile.f ====
verilog/bus_pkg.sv
verilog/cache_pkg.sv
verilog/lsu_control.sv
verilog/byte_lane_issue.sv
verilog/read_assembler.sv
verilog/word_cache.sv
verilog/wb8_lsu_top.sv
verification/wb8_mem_model.sv
verification/wb8_lsu_tb.sv
